// File: verif/cnn_golden.txt
# name kernel(tap2 tap1 tap0) pool rand_ready ncols then hex columns, row 0 in the low byte
# nbeats then per expected beat: data(hex) keep(hex) last
identity 001000 0 0 4 04030201 281E140A 7F640500 40090807
4 04030201 f 0 281E140A f 0 7F640500 f 0 40090807 f 1
edge_negative 010201 0 0 5 01806410 02803220 038000F0 0480CEC0 05809C08
5 00FD0F04 f 0 00FC0C04 f 0 00FC00FF f 0 01FCFEFE f 0 00FDFEFF f 1
saturation 7F7F7F 0 0 3 01008064 00008064 00008064
3 0700807F f 0 0700807F f 0 0000807F f 1
pooling 001000 1 0 6 02010905 00040307 281E0A14 2D23190F 00000000 64000001
3 00000409 3 0 00002D19 3 0 00006401 3 1
backpressure 010201 0 1 5 01806410 02803220 038000F0 0480CEC0 05809C08
5 00FD0F04 f 0 00FC0C04 f 0 00FC00FF f 0 01FCFEFE f 0 00FDFEFF f 1
reconfig_pool 001000 1 0 4 08000103 01090602 0D0C0B0A 3C000032
2 00000906 3 0 00003C32 3 1
reconfig_shift 100000 0 0 3 04030201 08070605 0C0B0A09
3 08070605 f 0 0C0B0A09 f 0 00000000 f 1

// File: cnn_stream.f
source/cnn_pkg.sv
source/kernel_config.sv
source/conv_row_engine.sv
source/lrelu_requant.sv
source/maxpool_unit.sv
source/cnn_stream_top.sv
verif/cnn_stream_tb.sv

// File: Bender.yml
package:
  name: cnn_stream

sources:
  - source/cnn_pkg.sv
  - source/kernel_config.sv
  - source/conv_row_engine.sv
  - source/lrelu_requant.sv
  - source/maxpool_unit.sv
  - source/cnn_stream_top.sv
  - target: test
    files:
      - verif/cnn_stream_tb.sv

// File: verif/cnn_stream_tb.sv
module cnn_stream_tb
  import cnn_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ns;

  logic             aclk;
  logic             i_rst_n;
  logic             i_cfg_strobe;
  kernel_t          i_cfg_kernel;
  logic             i_cfg_pool;
  logic             i_pix_valid;
  logic             o_pix_ready;
  column_t          i_pix_data;
  logic             i_pix_last;
  logic             o_res_valid;
  logic             i_res_ready;
  column_t          o_res_data;
  logic [UNITS-1:0] o_res_keep;
  logic             o_res_last;

  // Test table from the golden file
  string            name_tab  [16];
  kernel_t          kern_tab  [16];
  logic             pool_tab  [16];
  logic             rnd_tab   [16];
  int               ncols_tab [16];
  int               nexp_tab  [16];
  column_t          col_tab   [16][16];
  column_t          exp_data  [16][16];
  logic [UNITS-1:0] exp_keep  [16][16];
  logic             exp_last  [16][16];
  int               n_tests;
  logic             loaded;

  int               cur_test;
  int               got;
  int               test_errors;
  int               passed;
  int               failed;
  logic             rnd_mode;
  integer           seed;
  logic [31:0]      rnd_word;

  cnn_stream_top uut (
    .aclk         (aclk),
    .i_rst_n      (i_rst_n),
    .i_cfg_strobe (i_cfg_strobe),
    .i_cfg_kernel (i_cfg_kernel),
    .i_cfg_pool   (i_cfg_pool),
    .i_pix_valid  (i_pix_valid),
    .o_pix_ready  (o_pix_ready),
    .i_pix_data   (i_pix_data),
    .i_pix_last   (i_pix_last),
    .o_res_valid  (o_res_valid),
    .i_res_ready  (i_res_ready),
    .o_res_data   (o_res_data),
    .o_res_keep   (o_res_keep),
    .o_res_last   (o_res_last)
  );

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  task automatic check_value(input string what, input logic [31:0] expv,
                             input logic [31:0] actv);
    if (expv !== actv) begin
      $display("Fail %s beat %0d %s: expected %h, actual %h",
               name_tab[cur_test], got, what, expv, actv);
      test_errors++;
    end
  endtask

  task automatic load_golden();
    int          fd;
    int          code;
    int          v_pool;
    int          v_rnd;
    int          v_n;
    int          v_last;
    logic [31:0] h_word;
    logic [31:0] h_keep;
    string       tok;
    string       rest;
    n_tests = 0;
    fd = $fopen("verif/cnn_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open verif/cnn_golden.txt, no tests were run");
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok.substr(0, 0) == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%h %d %d %d", h_word, v_pool, v_rnd, v_n);
          name_tab[n_tests]  = tok;
          kern_tab[n_tests]  = h_word[KERNEL_W*WORD_WIDTH-1:0];
          pool_tab[n_tests]  = v_pool[0];
          rnd_tab[n_tests]   = v_rnd[0];
          ncols_tab[n_tests] = v_n;
          for (int i = 0; i < v_n; i++) begin
            code = $fscanf(fd, "%h", h_word);
            col_tab[n_tests][i] = h_word;
          end
          code = $fscanf(fd, "%d", v_n);
          nexp_tab[n_tests] = v_n;
          for (int i = 0; i < v_n; i++) begin
            code = $fscanf(fd, "%h %h %d", h_word, h_keep, v_last);
            exp_data[n_tests][i] = h_word;
            exp_keep[n_tests][i] = h_keep[UNITS-1:0];
            exp_last[n_tests][i] = v_last[0];
          end
          n_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Drives one row and holds each column while stalled
  task automatic send_row(input int t);
    for (int i = 0; i < ncols_tab[t]; i++) begin
      i_pix_valid <= 1'b1;
      i_pix_data  <= col_tab[t][i];
      i_pix_last  <= (i == ncols_tab[t] - 1);
      @(posedge aclk);
      while (!o_pix_ready) begin
        @(posedge aclk);
      end
    end
    i_pix_valid <= 1'b0;
    i_pix_last  <= 1'b0;
  endtask

  task automatic run_test(input int t);
    int    waited;
    string verdict;
    @(negedge aclk);
    cur_test    = t;
    got         = 0;
    test_errors = 0;
    @(posedge aclk);
    rnd_mode     <= rnd_tab[t];
    i_cfg_strobe <= 1'b1;
    i_cfg_kernel <= kern_tab[t];
    i_cfg_pool   <= pool_tab[t];
    @(posedge aclk);
    i_cfg_strobe <= 1'b0;
    send_row(t);
    waited = 0;
    while (got < nexp_tab[t] && waited < 10 * ncols_tab[t] + 20) begin
      @(negedge aclk);
      waited++;
    end
    if (got < nexp_tab[t]) begin
      $display("Test %s: only %0d of %0d result beats arrived",
               name_tab[t], got, nexp_tab[t]);
      test_errors++;
    end
    @(posedge aclk);
    rnd_mode <= 1'b0;
    // Quiet window so late extra beats still get caught
    repeat (6) @(negedge aclk);
    if (test_errors == 0) begin
      passed++;
      verdict = "ok";
    end else begin
      failed++;
      verdict = "fail";
    end
    $display("Test %-16s %s, %0d beats, %0d errors", name_tab[t], verdict, got, test_errors);
  endtask

  always @(posedge aclk) begin
    rnd_word = $random(seed);
    i_res_ready <= rnd_mode ? rnd_word[0] : 1'b1;
  end

  // Output monitor checks beats in arrival order
  always @(posedge aclk) begin
    if (i_rst_n && o_res_valid && i_res_ready) begin
      if (got < nexp_tab[cur_test]) begin
        check_value("data", exp_data[cur_test][got], o_res_data);
        check_value("keep", 32'(exp_keep[cur_test][got]), 32'(o_res_keep));
        check_value("last", 32'(exp_last[cur_test][got]), 32'(o_res_last));
      end else begin
        $display("Test %s: extra result beat %h beyond the %0d expected",
                 name_tab[cur_test], o_res_data, nexp_tab[cur_test]);
        test_errors++;
      end
      got++;
    end
  end

  initial begin
    int limit;
    wait (loaded);
    limit = 200;
    for (int t = 0; t < n_tests; t++) begin
      limit += 20 * ncols_tab[t];
    end
    repeat (limit) @(posedge aclk);
    $display("Watchdog expired after %0d cycles, the pipeline stopped responding", limit);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    i_rst_n      = 1'b0;
    i_cfg_strobe = 1'b0;
    i_cfg_kernel = '0;
    i_cfg_pool   = 1'b0;
    i_pix_valid  = 1'b0;
    i_pix_data   = '0;
    i_pix_last   = 1'b0;
    i_res_ready  = 1'b1;
    rnd_mode     = 1'b0;
    seed         = 32'hbc13d8fd;
    cur_test     = 0;
    got          = 0;
    test_errors  = 0;
    passed       = 0;
    failed       = 0;
    loaded       = 1'b0;
    load_golden();
    loaded = 1'b1;
    repeat (8) @(posedge aclk);
    i_rst_n <= 1'b1;
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests run, %0d passed, %0d failed", n_tests, passed, failed);
    if (failed == 0 && n_tests > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: source/cnn_stream_top.sv
module cnn_stream_top
  import cnn_pkg::*;
(
  input  logic             aclk,
  input  logic             i_rst_n,
  input  logic             i_cfg_strobe,
  input  kernel_t          i_cfg_kernel,
  input  logic             i_cfg_pool,
  input  logic             i_pix_valid,
  output logic             o_pix_ready,
  input  column_t          i_pix_data,
  input  logic             i_pix_last,
  output logic             o_res_valid,
  input  logic             i_res_ready,
  output column_t          o_res_data,
  output logic [UNITS-1:0] o_res_keep,
  output logic             o_res_last
);

  kernel_t     kernel;
  logic        pool_en;
  logic        busy;

  logic        conv_valid;
  logic        conv_ready;
  acc_column_t conv_data;
  logic        conv_last;

  logic        act_valid;
  logic        act_ready;
  column_t     act_data;
  logic        act_last;

  // Anything still in flight blocks reconfiguration
  assign busy = !o_pix_ready || conv_valid || act_valid || o_res_valid;

  kernel_config u_kernel_config (
    .aclk         (aclk),
    .i_rst_n      (i_rst_n),
    .i_cfg_strobe (i_cfg_strobe),
    .i_cfg_kernel (i_cfg_kernel),
    .i_cfg_pool   (i_cfg_pool),
    .i_busy       (busy),
    .o_kernel     (kernel),
    .o_pool_en    (pool_en)
  );

  conv_row_engine u_conv (
    .aclk     (aclk),
    .i_rst_n  (i_rst_n),
    .i_kernel (kernel),
    .i_valid  (i_pix_valid),
    .o_ready  (o_pix_ready),
    .i_data   (i_pix_data),
    .i_last   (i_pix_last),
    .o_valid  (conv_valid),
    .i_ready  (conv_ready),
    .o_data   (conv_data),
    .o_last   (conv_last)
  );

  lrelu_requant u_lrelu (
    .aclk    (aclk),
    .i_rst_n (i_rst_n),
    .i_valid (conv_valid),
    .o_ready (conv_ready),
    .i_data  (conv_data),
    .i_last  (conv_last),
    .o_valid (act_valid),
    .i_ready (act_ready),
    .o_data  (act_data),
    .o_last  (act_last)
  );

  maxpool_unit u_maxpool (
    .aclk      (aclk),
    .i_rst_n   (i_rst_n),
    .i_pool_en (pool_en),
    .i_valid   (act_valid),
    .o_ready   (act_ready),
    .i_data    (act_data),
    .i_last    (act_last),
    .o_valid   (o_res_valid),
    .i_ready   (i_res_ready),
    .o_data    (o_res_data),
    .o_keep    (o_res_keep),
    .o_last    (o_res_last)
  );

endmodule

// File: source/maxpool_unit.sv
module maxpool_unit
  import cnn_pkg::*;
(
  input  logic             aclk,
  input  logic             i_rst_n,
  input  logic             i_pool_en,
  input  logic             i_valid,
  output logic             o_ready,
  input  column_t          i_data,
  input  logic             i_last,
  output logic             o_valid,
  input  logic             i_ready,
  output column_t          o_data,
  output logic [UNITS-1:0] o_keep,
  output logic             o_last
);

  pool_state_e                     state;
  logic [UNITS/2*WORD_WIDTH-1:0]   pair_max;
  logic [UNITS/2*WORD_WIDTH-1:0]   held_max;
  column_t                         pooled;
  logic                            in_fire;
  logic                            out_free;

  assign out_free = !o_valid || i_ready;
  assign o_ready  = out_free;
  assign in_fire  = i_valid && o_ready;

  // Row pair maxima of the incoming column, then against the held even column
  always_comb begin
    word_t a;
    word_t b;
    word_t m;
    word_t h;
    pooled = '0;
    for (int k = 0; k < UNITS/2; k++) begin
      a = word_t'(i_data[(2*k)*WORD_WIDTH +: WORD_WIDTH]);
      b = word_t'(i_data[(2*k+1)*WORD_WIDTH +: WORD_WIDTH]);
      m = (a > b) ? a : b;
      h = word_t'(held_max[k*WORD_WIDTH +: WORD_WIDTH]);
      pair_max[k*WORD_WIDTH +: WORD_WIDTH] = m;
      pooled[k*WORD_WIDTH +: WORD_WIDTH]   = (m > h) ? m : h;
    end
  end

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= POOL_EVEN;
      o_valid <= 1'b0;
      o_last  <= 1'b0;
      o_keep  <= '0;
    end else begin
      if (out_free) begin
        o_valid <= 1'b0;
      end
      if (in_fire) begin
        if (!i_pool_en) begin
          o_valid <= 1'b1;
          o_last  <= i_last;
          o_keep  <= '1;
        end else if (state == POOL_EVEN) begin
          state <= POOL_ODD;
        end else begin
          state   <= POOL_EVEN;
          o_valid <= 1'b1;
          o_last  <= i_last;
          o_keep  <= UNITS'({(UNITS/2){1'b1}});
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (in_fire) begin
      if (!i_pool_en) begin
        o_data <= i_data;
      end else if (state == POOL_EVEN) begin
        held_max <= pair_max;
      end else begin
        o_data <= pooled;
      end
    end
  end

  // Pooled rows need an even column count
  a_last_odd : assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    (in_fire && i_pool_en && i_last) |-> (state == POOL_ODD)
  ) else $error("maxpool_unit: row ended on an even column with pooling on");

endmodule

// File: source/lrelu_requant.sv
module lrelu_requant
  import cnn_pkg::*;
(
  input  logic        aclk,
  input  logic        i_rst_n,
  input  logic        i_valid,
  output logic        o_ready,
  input  acc_column_t i_data,
  input  logic        i_last,
  output logic        o_valid,
  input  logic        i_ready,
  output column_t     o_data,
  output logic        o_last
);

  column_t act_col;
  logic    in_fire;

  assign o_ready = !o_valid || i_ready;
  assign in_fire = i_valid && o_ready;

  always_comb begin
    acc_t v;
    acc_t q;
    for (int u = 0; u < UNITS; u++) begin
      v = acc_t'(i_data[u*ACC_WIDTH +: ACC_WIDTH]);
      if (v[ACC_WIDTH-1]) begin
        v = v >>> LRELU_SHIFT;
      end
      q = v >>> QUANT_SHIFT;
      // Fits when all bits above the word sign agree
      if (&q[ACC_WIDTH-1:WORD_WIDTH-1] || ~|q[ACC_WIDTH-1:WORD_WIDTH-1]) begin
        act_col[u*WORD_WIDTH +: WORD_WIDTH] = q[WORD_WIDTH-1:0];
      end else if (q[ACC_WIDTH-1]) begin
        act_col[u*WORD_WIDTH +: WORD_WIDTH] = {1'b1, {(WORD_WIDTH-1){1'b0}}};
      end else begin
        act_col[u*WORD_WIDTH +: WORD_WIDTH] = {1'b0, {(WORD_WIDTH-1){1'b1}}};
      end
    end
  end

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
      o_last  <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
      if (i_valid) begin
        o_last <= i_last;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (in_fire) begin
      o_data <= act_col;
    end
  end

endmodule

// File: source/conv_row_engine.sv
module conv_row_engine
  import cnn_pkg::*;
(
  input  logic        aclk,
  input  logic        i_rst_n,
  input  kernel_t     i_kernel,
  input  logic        i_valid,
  output logic        o_ready,
  input  column_t     i_data,
  input  logic        i_last,
  output logic        o_valid,
  input  logic        i_ready,
  output acc_column_t o_data,
  output logic        o_last
);

  column_t     prev_col;
  column_t     cur_col;
  column_t     left_col;
  column_t     right_col;
  acc_column_t sums;
  word_t       tap_l;
  word_t       tap_c;
  word_t       tap_r;
  logic        cur_valid;
  logic        row_start;
  logic        flush_pending;
  logic        in_fire;
  logic        out_free;

  assign tap_l = word_t'(i_kernel[0*WORD_WIDTH +: WORD_WIDTH]);
  assign tap_c = word_t'(i_kernel[1*WORD_WIDTH +: WORD_WIDTH]);
  assign tap_r = word_t'(i_kernel[2*WORD_WIDTH +: WORD_WIDTH]);

  assign out_free = !o_valid || i_ready;
  // No new column while the flush beat is waiting
  assign o_ready  = !flush_pending && out_free;
  assign in_fire  = i_valid && o_ready;

  // Zero padding on both row ends
  assign left_col  = row_start ? '0 : prev_col;
  assign right_col = flush_pending ? '0 : i_data;

  always_comb begin
    acc_t acc;
    for (int u = 0; u < UNITS; u++) begin
      acc = tap_l * word_t'(left_col[u*WORD_WIDTH +: WORD_WIDTH])
          + tap_c * word_t'(cur_col[u*WORD_WIDTH +: WORD_WIDTH])
          + tap_r * word_t'(right_col[u*WORD_WIDTH +: WORD_WIDTH]);
      sums[u*ACC_WIDTH +: ACC_WIDTH] = acc;
    end
  end

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid       <= 1'b0;
      o_last        <= 1'b0;
      cur_valid     <= 1'b0;
      row_start     <= 1'b0;
      flush_pending <= 1'b0;
    end else begin
      if (out_free) begin
        o_valid <= 1'b0;
      end
      if (flush_pending && out_free) begin
        o_valid       <= 1'b1;
        o_last        <= 1'b1;
        flush_pending <= 1'b0;
        cur_valid     <= 1'b0;
      end else if (in_fire) begin
        // First column of a row only primes the window
        if (cur_valid) begin
          o_valid <= 1'b1;
          o_last  <= 1'b0;
        end
        cur_valid     <= 1'b1;
        row_start     <= !cur_valid;
        flush_pending <= i_last;
      end
    end
  end

  // Window and result payload
  always_ff @(posedge aclk) begin
    if (flush_pending && out_free) begin
      o_data <= sums;
    end else if (in_fire) begin
      if (cur_valid) begin
        o_data <= sums;
      end
      prev_col <= cur_col;
      cur_col  <= i_data;
    end
  end

  a_in_stable : assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    (i_valid && !o_ready) |=> ($stable(i_data) && $stable(i_last))
  ) else $error("conv_row_engine: pixel beat changed while stalled");

endmodule

// File: source/kernel_config.sv
module kernel_config
  import cnn_pkg::*;
(
  input  logic    aclk,
  input  logic    i_rst_n,
  input  logic    i_cfg_strobe,
  input  kernel_t i_cfg_kernel,
  input  logic    i_cfg_pool,
  input  logic    i_busy,
  output kernel_t o_kernel,
  output logic    o_pool_en
);

  // Taps and pool mode hold until the next strobe
  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_kernel  <= '0;
      o_pool_en <= 1'b0;
    end else if (i_cfg_strobe) begin
      o_kernel  <= i_cfg_kernel;
      o_pool_en <= i_cfg_pool;
    end
  end

  // A new kernel while beats are in flight would mix two configurations
  a_cfg_idle : assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    i_cfg_strobe |-> !i_busy
  ) else $error("kernel_config: configuration strobe while pipeline busy");

endmodule

// File: source/cnn_pkg.sv
package cnn_pkg;

  // Layer geometry
  localparam int UNITS      = 4;
  localparam int WORD_WIDTH = 8;
  localparam int ACC_WIDTH  = 20;
  localparam int KERNEL_W   = 3;

  // Leaky ReLU alpha of 1/8 applied as a shift on negative sums
  localparam int LRELU_SHIFT = 3;

  // Accumulator scale down to output scale
  localparam int QUANT_SHIFT = 4;

  typedef logic signed [WORD_WIDTH-1:0] word_t;
  typedef logic signed [ACC_WIDTH-1:0]  acc_t;

  // Row u sits at [u*WORD_WIDTH +: WORD_WIDTH], row 0 in the low bits
  typedef logic [UNITS*WORD_WIDTH-1:0] column_t;

  // Same order as column_t, ACC_WIDTH bits per row
  typedef logic [UNITS*ACC_WIDTH-1:0] acc_column_t;

  // Tap 0 multiplies column c-1, tap 2 column c+1
  typedef logic [KERNEL_W*WORD_WIDTH-1:0] kernel_t;

  // Column parity inside a row while pooling
  typedef enum logic {
    POOL_EVEN,
    POOL_ODD
  } pool_state_e;

endpackage
